//--- all.f
hdl/uart_pkg.sv
hdl/uart_baud_gen.sv
hdl/uart_credit_fifo.sv
hdl/uart_serializer.sv
hdl/uart_deserializer.sv
hdl/uart_subsystem.sv
dv/uart_subsystem_tb.sv

//--- dv/uart_subsystem_tb.sv
// UART subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module uart_subsystem_tb;

  localparam int CLKS_PER_OS = 4;
  localparam int TX_DEPTH    = 4;
  localparam int RX_DEPTH    = 4;
  localparam int OUT_CREDITS = 2;
  localparam int BIT_CLKS    = uart_pkg::os_rate * CLKS_PER_OS;
  localparam int FRAME_CLKS  = 13 * BIT_CLKS; // longest frame plus idle gap
  localparam int N_FRAMES    = 40 + 4 + 2 + OUT_CREDITS + RX_DEPTH + 2 + 1;
  localparam int WATCHDOG_NS = 2 * N_FRAMES * FRAME_CLKS * 8;

  logic clk, reset_n, in_valid, in_credit, tx, tx_busy, rx;
  logic out_valid, out_frame_err, out_overrun, out_credit;
  logic loopback, rx_bang, sink_release;
  uart_pkg::byte_t     in_data, out_data;
  uart_pkg::stop_cfg_e stop_cfg;

  uart_pkg::rx_word_t exp_q [$]; // expected words, in order
  int sent_cnt = 0, in_credit_cnt = 0;
  int pops_seen = 0, credits_returned = 0;

  assign rx = loopback ? tx : rx_bang;

  uart_subsystem #(
    .CLKS_PER_OS(CLKS_PER_OS),
    .TX_DEPTH   (TX_DEPTH),
    .RX_DEPTH   (RX_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) uart_subsystem_inst (
    .clk(clk), .reset_n(reset_n), .in_valid(in_valid), .in_data(in_data),
    .in_credit(in_credit), .stop_cfg(stop_cfg), .tx(tx), .tx_busy(tx_busy),
    .rx(rx), .out_valid(out_valid), .out_data(out_data),
    .out_frame_err(out_frame_err), .out_overrun(out_overrun), .out_credit(out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_word(input uart_pkg::rx_word_t got, input uart_pkg::rx_word_t exp);
    if (got !== exp)
      abort_run($sformatf({"Mismatch at %0t: word data %h frame_err %b overrun %b, ",
        "expected data %h frame_err %b overrun %b"}, $time, got.data, got.frame_err,
        got.overrun, exp.data, exp.frame_err, exp.overrun));
  endtask

  task automatic check_frame_len(input int got, input int exp);
    if (got != exp)
      abort_run($sformatf("Mismatch at %0t: frame took %0d clocks, expected %0d",
        $time, got, exp));
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
      abort_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  function automatic int stop_half(input uart_pkg::stop_cfg_e cfg);
    case (cfg)
      uart_pkg::stop_1:   return 2;
      uart_pkg::stop_1p5: return 3;
      default:            return 4; // 3 counts as two stop bits
    endcase
  endfunction

  function automatic uart_pkg::stop_cfg_e rand_cfg();
    return uart_pkg::stop_cfg_e'($urandom_range(3));
  endfunction

  task automatic expect_word(input uart_pkg::byte_t b, input logic fe, input logic ov);
    uart_pkg::rx_word_t w;
    w = '{data: b, frame_err: fe, overrun: ov};
    exp_q.push_back(w);
  endtask

  // one push per source credit
  task automatic send_byte(input uart_pkg::byte_t b, input uart_pkg::stop_cfg_e cfg);
    while (TX_DEPTH - sent_cnt + in_credit_cnt == 0)
      wait_clks(1);
    in_valid = 1'b1;
    in_data  = b;
    stop_cfg = cfg;
    sent_cnt++;
    wait_clks(1);
    in_valid = 1'b0;
  endtask

  task automatic measure_frame(output int clks);
    while (tx !== 1'b0)
      wait_clks(1);
    clks = 0;
    while (tx_busy !== 1'b0) begin
      wait_clks(1);
      clks++;
    end
  endtask

  task automatic bang_frame(input uart_pkg::byte_t b, input logic stop_bit);
    rx_bang = 1'b0;
    wait_clks(BIT_CLKS);
    for (int i = 0; i < uart_pkg::data_w; i++) begin
      rx_bang = b[i]; // LSB first
      wait_clks(BIT_CLKS);
    end
    rx_bang = stop_bit;
    wait_clks(BIT_CLKS);
    rx_bang = 1'b1;
    wait_clks(2 * BIT_CLKS);
  endtask

  // wait until tx stays idle for two bit times
  task automatic drain_tx();
    int idle_clks;
    idle_clks = 0;
    while (idle_clks < 2 * BIT_CLKS) begin
      wait_clks(1);
      idle_clks = tx_busy ? 0 : idle_clks + 1;
    end
  endtask

  task automatic wait_words_done();
    while (exp_q.size() != 0 || pops_seen != credits_returned)
      wait_clks(1);
  endtask

  // output and credit monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (reset_n) begin
      if (in_credit) begin
        in_credit_cnt++;
        if (in_credit_cnt > sent_cnt)
          abort_run("source holds more credits than the transmit FIFO depth");
      end
      if (out_valid) begin
        if (exp_q.size() == 0)
          abort_run("output word arrived while none was expected");
        if (pops_seen - credits_returned >= OUT_CREDITS)
          abort_run("output word delivered without a sink credit");
        check_word({out_data, out_frame_err, out_overrun}, exp_q[0]);
        exp_q.delete(0);
        pops_seen++;
      end
    end
  end

  // sink returns one credit per cycle when allowed
  initial begin
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (sink_release && pops_seen > credits_returned) begin
        out_credit = 1'b1;
        credits_returned++;
      end else begin
        out_credit = 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests completed");
  end

  initial begin
    uart_pkg::byte_t b;
    int clks;
    int pops_before;
    void'($urandom(32'h8c2b_e221));
    reset_n  = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    stop_cfg = uart_pkg::stop_1;
    loopback = 1'b1;
    rx_bang  = 1'b1;
    sink_release = 1'b1;
    wait_clks(8);
    if (tx !== 1'b1 || tx_busy !== 1'b0 || out_valid !== 1'b0 || in_credit !== 1'b0)
      abort_run("outputs not at their reset values");
    reset_n = 1'b1;
    wait_clks(2);

    for (int i = 0; i < 40; i++) begin
      b = uart_pkg::byte_t'($urandom);
      expect_word(b, 1'b0, 1'b0);
      send_byte(b, rand_cfg());
    end
    drain_tx();
    wait_words_done();
    check_count("in_credit pulses", in_credit_cnt, sent_cnt);

    for (int c = 0; c < 4; c++) begin
      b = uart_pkg::byte_t'($urandom);
      expect_word(b, 1'b0, 1'b0);
      send_byte(b, uart_pkg::stop_cfg_e'(c));
      measure_frame(clks);
      check_frame_len(clks, (18 + stop_half(uart_pkg::stop_cfg_e'(c))) * 8 * CLKS_PER_OS);
      drain_tx();
    end
    wait_words_done();

    loopback = 1'b0; // bit-banged frames
    b = uart_pkg::byte_t'($urandom);
    expect_word(b, 1'b1, 1'b0);
    bang_frame(b, 1'b0);
    b = uart_pkg::byte_t'($urandom);
    expect_word(b, 1'b0, 1'b0);
    bang_frame(b, 1'b1);
    wait_words_done();
    loopback = 1'b1;

    sink_release = 1'b0;
    pops_before  = pops_seen;
    for (int i = 0; i < OUT_CREDITS + RX_DEPTH + 2; i++) begin
      b = uart_pkg::byte_t'($urandom);
      if (i < OUT_CREDITS + RX_DEPTH)
        expect_word(b, 1'b0, 1'b0); // last two get dropped
      send_byte(b, rand_cfg());
    end
    drain_tx();
    check_count("words delivered with credits withheld", pops_seen - pops_before, OUT_CREDITS);
    sink_release = 1'b1;
    wait_words_done();
    b = uart_pkg::byte_t'($urandom);
    expect_word(b, 1'b0, 1'b1);
    send_byte(b, rand_cfg());
    drain_tx();
    wait_words_done();

    if (in_credit_cnt == sent_cnt) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run($sformatf("Mismatch at %0t: in_credit pulses %0d, expected %0d",
        $time, in_credit_cnt, sent_cnt));
    end
  end

endmodule

`default_nettype wire

//--- hdl/uart_baud_gen.sv
// UART baud tick generator
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen #(
  parameter int CLKS_PER_OS = 4
) (
  input  logic clk,
  input  logic reset_n,
  output logic os_tick,
  output logic half_tick
);

  localparam int DIV_W   = (CLKS_PER_OS > 1) ? $clog2(CLKS_PER_OS) : 1;
  localparam int HALF_OS = uart_pkg::os_rate / 2; // os ticks per half-bit
  localparam int PH_W    = $clog2(HALF_OS);

  logic [DIV_W-1:0] div_cnt;
  logic [PH_W-1:0]  phase;
  logic             div_wrap;

  assign div_wrap = (div_cnt == DIV_W'(CLKS_PER_OS - 1));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      div_cnt   <= '0;
      phase     <= '0;
      os_tick   <= 1'b0;
      half_tick <= 1'b0;
    end else begin
      div_cnt   <= div_wrap ? '0 : div_cnt + 1'b1;
      os_tick   <= div_wrap;
      half_tick <= div_wrap && (phase == PH_W'(HALF_OS - 1));
      if (div_wrap)
        phase <= phase + 1'b1; // wraps every half-bit
    end
  end

endmodule

`default_nettype wire

//--- hdl/uart_credit_fifo.sv
// credit flow-controlled FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_credit_fifo #(
  parameter type payload_t   = logic [7:0],
  parameter int  DEPTH       = 4,
  parameter int  POP_CREDITS = 1
) (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     push_valid,
  input  payload_t push_payload,
  output logic     push_credit,
  output logic     pop_valid,
  output payload_t pop_payload,
  input  logic     pop_credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(POP_CREDITS + 1);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credit_cnt; // credits held toward the consumer
  logic             do_pop;

  assign do_pop      = (count != '0) && (credit_cnt != '0);
  assign pop_valid   = do_pop;
  assign pop_payload = mem[rd_ptr];
  assign push_credit = do_pop; // slot freed this cycle

  always_ff @(posedge clk) begin
    if (push_valid)
      mem[wr_ptr] <= push_payload;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_cnt <= CRD_W'(POP_CREDITS);
    end else begin
      if (push_valid)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count      <= count + CNT_W'(push_valid) - CNT_W'(do_pop);
      credit_cnt <= credit_cnt + CRD_W'(pop_credit) - CRD_W'(do_pop);
    end
  end

  // sender must hold a credit per push
  no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
    !(push_valid && count == CNT_W'(DEPTH)));

  // consumer never returns more than it was granted
  credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
    credit_cnt <= CRD_W'(POP_CREDITS));

endmodule

`default_nettype wire

//--- hdl/uart_deserializer.sv
// UART 16x oversampling receiver
`timescale 1ns/1ps
`default_nettype none

module uart_deserializer #(
  parameter int RX_DEPTH = 4
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               os_tick,
  input  logic               rx,
  output logic               push_valid,
  output uart_pkg::rx_word_t push_word,
  input  logic               push_credit
);

  localparam int S_IDLE  = 0;
  localparam int S_START = 1;
  localparam int S_DATA  = 2;
  localparam int S_STOP  = 3;
  localparam int OS_W    = $clog2(uart_pkg::os_rate);
  localparam int BIT_W   = $clog2(uart_pkg::data_w);
  localparam int CRD_W   = $clog2(RX_DEPTH + 1);
  localparam int MID     = uart_pkg::os_rate / 2 - 1;
  localparam int LAST    = uart_pkg::os_rate - 1;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev; // line at previous os_tick
  logic [3:0]       state;
  logic [OS_W-1:0]  os_cnt;
  logic [BIT_W-1:0] bit_cnt;
  uart_pkg::byte_t  data_sr;
  logic [CRD_W-1:0] credit_cnt;
  logic             ovr_pending;
  logic             stop_sample;
  logic             do_push;

  assign stop_sample = os_tick && state[S_STOP] && (os_cnt == OS_W'(LAST));
  assign do_push     = stop_sample && (credit_cnt != '0);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rx_prev <= 1'b1;
      state   <= 4'b0001;
      os_cnt  <= '0;
      bit_cnt <= '0;
    end else if (os_tick) begin
      rx_prev <= rx_sync;
      os_cnt  <= os_cnt + 1'b1;
      unique case (1'b1)
        state[S_IDLE]: begin
          os_cnt <= OS_W'(1);
          if (rx_prev && !rx_sync)
            state <= 4'b0010; // falling edge
        end
        state[S_START]: begin
          if (os_cnt == OS_W'(MID)) begin
            os_cnt  <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? 4'b0001 : 4'b0100; // reject glitch
          end
        end
        state[S_DATA]: begin
          if (os_cnt == OS_W'(LAST)) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(uart_pkg::data_w - 1))
              state <= 4'b1000;
          end
        end
        state[S_STOP]: begin
          if (os_cnt == OS_W'(LAST))
            state <= 4'b0001;
        end
        default: state <= 4'b0001;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (os_tick && state[S_DATA] && os_cnt == OS_W'(LAST))
      data_sr <= {rx_sync, data_sr[uart_pkg::data_w-1:1]};
    if (do_push) begin
      push_word.data      <= data_sr;
      push_word.frame_err <= !rx_sync;
      push_word.overrun   <= ovr_pending;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      push_valid  <= 1'b0;
      credit_cnt  <= CRD_W'(RX_DEPTH);
      ovr_pending <= 1'b0;
    end else begin
      push_valid <= do_push;
      credit_cnt <= credit_cnt + CRD_W'(push_credit) - CRD_W'(do_push);
      if (do_push)
        ovr_pending <= 1'b0;
      else if (stop_sample)
        ovr_pending <= 1'b1; // no room, word lost
    end
  end

  rx_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
    credit_cnt <= CRD_W'(RX_DEPTH));

endmodule

`default_nettype wire

//--- hdl/uart_pkg.sv
// UART shared definitions
`default_nettype none

package uart_pkg;

  localparam int data_w  = 8;
  localparam int os_rate = 16; // rx oversampling ratio

  // stop length in half-bits: 2, 3 or 4
  typedef enum logic [1:0] {
    stop_1   = 2'd0,
    stop_1p5 = 2'd1,
    stop_2   = 2'd2
  } stop_cfg_e; // 3 decodes as stop_2

  typedef logic [data_w-1:0] byte_t;

  typedef struct packed {
    byte_t data;
    logic  frame_err; // first stop bit sampled low
    logic  overrun;   // words were dropped before this one
  } rx_word_t;

endpackage

`default_nettype wire

//--- hdl/uart_serializer.sv
// UART frame transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_serializer (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                half_tick,
  input  logic                start_valid,
  input  uart_pkg::byte_t     data,
  input  uart_pkg::stop_cfg_e stop_cfg,
  output logic                tx,
  output logic                busy,
  output logic                credit
);

  localparam int S_IDLE  = 0;
  localparam int S_START = 1;
  localparam int S_DATA  = 2;
  localparam int S_STOP  = 3;
  localparam int BIT_W   = $clog2(uart_pkg::data_w);

  logic [3:0]       state; // one-hot
  uart_pkg::byte_t  shift_reg;
  logic [BIT_W-1:0] bit_cnt;
  logic [1:0]       half_cnt;
  logic [1:0]       stop_last; // stop half-bits minus one
  logic             stop_done;

  assign busy      = !state[S_IDLE];
  assign stop_done = state[S_STOP] && (half_cnt == stop_last);
  assign credit    = half_tick && stop_done;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= 4'b0001;
      tx       <= 1'b1;
      bit_cnt  <= '0;
      half_cnt <= '0;
    end else if (state[S_IDLE]) begin
      if (start_valid) begin
        state    <= 4'b0010;
        half_cnt <= '0; // tx drops on the next half_tick
      end
    end else if (half_tick) begin
      unique case (1'b1)
        state[S_START]: begin
          half_cnt <= half_cnt + 1'b1;
          if (half_cnt == 2'd0) begin
            tx <= 1'b0;
          end else if (half_cnt == 2'd2) begin
            tx       <= shift_reg[0];
            state    <= 4'b0100;
            half_cnt <= '0;
            bit_cnt  <= '0;
          end
        end
        state[S_DATA]: begin
          if (half_cnt == 2'd0) begin
            half_cnt <= 2'd1;
          end else if (bit_cnt == BIT_W'(uart_pkg::data_w - 1)) begin
            tx       <= 1'b1;
            state    <= 4'b1000;
            half_cnt <= '0;
          end else begin
            tx       <= shift_reg[0];
            bit_cnt  <= bit_cnt + 1'b1;
            half_cnt <= '0;
          end
        end
        state[S_STOP]: begin
          half_cnt <= half_cnt + 1'b1;
          if (stop_done)
            state <= 4'b0001;
        end
        default: state <= 4'b0001;
      endcase
    end
  end

  // frame payload, latched on accept
  always_ff @(posedge clk) begin
    if (state[S_IDLE] && start_valid) begin
      shift_reg <= data;
      unique case (stop_cfg)
        uart_pkg::stop_1:   stop_last <= 2'd1;
        uart_pkg::stop_1p5: stop_last <= 2'd2;
        default:            stop_last <= 2'd3;
      endcase
    end else if (half_tick && (state[S_START] && half_cnt == 2'd2 ||
                               state[S_DATA] && half_cnt == 2'd1)) begin
      shift_reg <= shift_reg >> 1; // LSB first
    end
  end

  no_start_busy: assert property (@(posedge clk) disable iff (!reset_n)
    start_valid |-> !busy);

endmodule

`default_nettype wire

//--- hdl/uart_subsystem.sv
// UART subsystem top
`timescale 1ns/1ps
`default_nettype none

module uart_subsystem #(
  parameter int CLKS_PER_OS = 4,
  parameter int TX_DEPTH    = 4,
  parameter int RX_DEPTH    = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                in_valid,
  input  uart_pkg::byte_t     in_data,
  output logic                in_credit,
  input  uart_pkg::stop_cfg_e stop_cfg,
  output logic                tx,
  output logic                tx_busy,
  input  logic                rx,
  output logic                out_valid,
  output uart_pkg::byte_t     out_data,
  output logic                out_frame_err,
  output logic                out_overrun,
  input  logic                out_credit
);

  logic               os_tick;
  logic               half_tick;
  logic               ser_start;
  uart_pkg::byte_t    ser_data;
  logic               ser_credit;
  logic               rx_push;
  uart_pkg::rx_word_t rx_push_word;
  logic               rx_push_credit;
  uart_pkg::rx_word_t rx_pop_word;

  assign out_data      = rx_pop_word.data;
  assign out_frame_err = rx_pop_word.frame_err;
  assign out_overrun   = rx_pop_word.overrun;

  uart_baud_gen #(.CLKS_PER_OS(CLKS_PER_OS)) baud_gen (
    .clk      (clk),
    .reset_n  (reset_n),
    .os_tick  (os_tick),
    .half_tick(half_tick)
  );

  // serializer takes one byte per frame
  uart_credit_fifo #(
    .payload_t  (uart_pkg::byte_t),
    .DEPTH      (TX_DEPTH),
    .POP_CREDITS(1)
  ) tx_fifo (
    .clk         (clk),
    .reset_n     (reset_n),
    .push_valid  (in_valid),
    .push_payload(in_data),
    .push_credit (in_credit),
    .pop_valid   (ser_start),
    .pop_payload (ser_data),
    .pop_credit  (ser_credit)
  );

  uart_serializer serializer (
    .clk        (clk),
    .reset_n    (reset_n),
    .half_tick  (half_tick),
    .start_valid(ser_start),
    .data       (ser_data),
    .stop_cfg   (stop_cfg),
    .tx         (tx),
    .busy       (tx_busy),
    .credit     (ser_credit)
  );

  uart_deserializer #(.RX_DEPTH(RX_DEPTH)) deserializer (
    .clk        (clk),
    .reset_n    (reset_n),
    .os_tick    (os_tick),
    .rx         (rx),
    .push_valid (rx_push),
    .push_word  (rx_push_word),
    .push_credit(rx_push_credit)
  );

  uart_credit_fifo #(
    .payload_t  (uart_pkg::rx_word_t),
    .DEPTH      (RX_DEPTH),
    .POP_CREDITS(OUT_CREDITS)
  ) rx_fifo (
    .clk         (clk),
    .reset_n     (reset_n),
    .push_valid  (rx_push),
    .push_payload(rx_push_word),
    .push_credit (rx_push_credit),
    .pop_valid   (out_valid),
    .pop_payload (rx_pop_word),
    .pop_credit  (out_credit)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the UART subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module uart_subsystem_tb -Mdir obj_dir -f all.f; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vuart_subsystem_tb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Regression failed" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
exit 0
